/* hdl/pwm_params.svh */
/*
  PWM controller constants
  Widths, channel count, register map offsets
*/
`ifndef PWM_PARAMS_SVH
`define PWM_PARAMS_SVH

// ====================
// Widths and sizes
// ====================
`define PWM_NUM_CH      4     // Output channels
`define PWM_CNT_W       16    // Counter, duty, dead-time
`define PWM_FILT_W      8     // Fault debounce length
`define PWM_DATA_W      32    // APB data
`define PWM_ADDR_W      8     // APB byte address

// ====================
// Register map
// ====================
`define PWM_GCR_OFS     8'h00
`define PWM_PERIOD_OFS  8'h04
`define PWM_PSC_OFS     8'h08
`define PWM_CNT_OFS     8'h0C // Live counter, read only
`define PWM_DT_OFS      8'h10 // Rise [15:0], fall [31:16]
`define PWM_FAULT_OFS   8'h14
`define PWM_IER_OFS     8'h18
`define PWM_ISR_OFS     8'h1C // Write 1 to clear

// Per channel block
`define PWM_CH_BASE     8'h40
`define PWM_CH_STRIDE   8'h10
`define PWM_CCR_OFS     8'h0
`define PWM_DUTY_OFS    8'h4

`endif

/* hdl/pwm_pkg.sv */
/*
  Shared types of the PWM controller
  Vector typedefs, config structs, APB request, dead-time states
*/
`default_nettype none
`include "pwm_params.svh"

package pwm_pkg;

  // ====================
  // Vector types
  // ====================
  typedef logic [`PWM_CNT_W-1:0]  pwm_cnt_t;   // Counter, period, duty, dead-time
  typedef logic [`PWM_CNT_W-1:0]  pwm_psc_t;   // Prescaler
  typedef logic [`PWM_FILT_W-1:0] pwm_filt_t;  // Fault filter length
  typedef logic [`PWM_DATA_W-1:0] pwm_data_t;
  typedef logic [`PWM_ADDR_W-1:0] pwm_addr_t;

  // APB request, no wait states
  typedef struct packed {
    logic      psel;
    logic      penable;
    logic      pwrite;
    pwm_addr_t paddr;
    pwm_data_t pwdata;
  } pwm_apb_req_t;

  // ====================
  // Configuration
  // ====================
  typedef struct packed {
    logic     en;       // Global enable
    logic     out_en;   // Master output gate
    pwm_cnt_t period;
    pwm_psc_t psc;
    pwm_cnt_t dt_rise;  // In ticks
    pwm_cnt_t dt_fall;
  } pwm_glb_cfg_t;

  typedef struct packed {
    logic     en;
    logic     pol;       // Invert polarized signal
    logic     comp_en;   // Drive pwm_n
    logic     dt_en;
    logic     fault_en;  // Shut down on fault flag
    pwm_cnt_t duty;
  } pwm_ch_cfg_t;

  typedef struct packed {
    logic      pol;       // Set for active low input
    logic      auto_clr;
    pwm_filt_t filt;
  } pwm_fault_cfg_t;

  // Dead-time sequencer
  typedef enum logic [1:0] {
    OFF,
    DT_RISE,
    ON,
    DT_FALL
  } pwm_dt_state_e;

endpackage

`default_nettype wire

/* hdl/pwm_regs.sv */
/*
  APB register file of the PWM controller
  Global and per channel config, read mux, IER/ISR, fault clear pulse
*/
`timescale 1ns/1ps
`default_nettype none
`include "pwm_params.svh"

module pwm_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  pwm_pkg::pwm_apb_req_t   apb_i,
  output pwm_pkg::pwm_data_t      prdata_o,
  input  pwm_pkg::pwm_cnt_t       cnt_i,
  input  logic                    wrap_i,
  input  logic                    fault_lvl_i,
  input  logic                    fault_flag_i,
  output logic                    fault_clr_o,
  output pwm_pkg::pwm_glb_cfg_t   glb_cfg_o,
  output pwm_pkg::pwm_fault_cfg_t fault_cfg_o,
  output pwm_pkg::pwm_ch_cfg_t    ch_cfg_o [`PWM_NUM_CH],
  output logic                    irq_o
);
  import pwm_pkg::*;

  localparam int CH_IDX_W = $clog2(`PWM_NUM_CH);

  pwm_glb_cfg_t           glb_q;
  pwm_fault_cfg_t         fault_q;
  pwm_ch_cfg_t            ch_q [`PWM_NUM_CH];
  logic [1:0]             ier_q;  // [0] wrap, [1] fault
  logic [1:0]             isr_q;
  logic                   wr_en;
  logic                   ch_hit;
  pwm_addr_t              ch_ofs;
  pwm_addr_t              ch_reg;
  logic [CH_IDX_W-1:0]    ch_idx;

  // ====================
  // Address decode
  // ====================
  assign wr_en  = apb_i.psel && apb_i.penable && apb_i.pwrite;  // Access phase write
  assign ch_ofs = apb_i.paddr - `PWM_CH_BASE;
  assign ch_hit = (apb_i.paddr >= `PWM_CH_BASE) &&
                  (apb_i.paddr < `PWM_CH_BASE + `PWM_NUM_CH * `PWM_CH_STRIDE);
  assign ch_idx = CH_IDX_W'(ch_ofs / `PWM_CH_STRIDE);
  assign ch_reg = ch_ofs % `PWM_CH_STRIDE;  // Offset inside channel block

  // Config registers
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      glb_q        <= '0;
      glb_q.period <= '1;  // Period resets to all ones
      fault_q      <= '0;
      ier_q        <= '0;
      for (int i = 0; i < `PWM_NUM_CH; i++) begin
        ch_q[i] <= '0;
      end
    end else if (wr_en) begin
      case (apb_i.paddr)
        `PWM_GCR_OFS: begin
          glb_q.en     <= apb_i.pwdata[0];
          glb_q.out_en <= apb_i.pwdata[1];
        end
        `PWM_PERIOD_OFS: glb_q.period <= apb_i.pwdata[`PWM_CNT_W-1:0];
        `PWM_PSC_OFS:    glb_q.psc    <= apb_i.pwdata[`PWM_CNT_W-1:0];
        `PWM_DT_OFS: begin
          glb_q.dt_rise <= apb_i.pwdata[`PWM_CNT_W-1:0];
          glb_q.dt_fall <= apb_i.pwdata[`PWM_CNT_W+15:16];
        end
        `PWM_FAULT_OFS: begin  // Bit 1 is the clear pulse, not stored
          fault_q.pol      <= apb_i.pwdata[2];
          fault_q.auto_clr <= apb_i.pwdata[3];
          fault_q.filt     <= apb_i.pwdata[`PWM_FILT_W+7:8];
        end
        `PWM_IER_OFS: ier_q <= apb_i.pwdata[1:0];
        default: ;
      endcase
      if (ch_hit && ch_reg == `PWM_CCR_OFS) begin
        ch_q[ch_idx].en       <= apb_i.pwdata[0];
        ch_q[ch_idx].pol      <= apb_i.pwdata[1];
        ch_q[ch_idx].comp_en  <= apb_i.pwdata[2];
        ch_q[ch_idx].dt_en    <= apb_i.pwdata[3];
        ch_q[ch_idx].fault_en <= apb_i.pwdata[4];
      end
      if (ch_hit && ch_reg == `PWM_DUTY_OFS) begin
        ch_q[ch_idx].duty <= apb_i.pwdata[`PWM_CNT_W-1:0];
      end
    end
  end

  // ====================
  // Interrupts
  // ====================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      isr_q <= '0;
    end else begin
      if (wr_en && apb_i.paddr == `PWM_ISR_OFS) begin
        isr_q <= isr_q & ~apb_i.pwdata[1:0];  // W1C
      end
      if (wrap_i)      isr_q[0] <= 1'b1;  // Events win over clear
      if (fault_lvl_i) isr_q[1] <= 1'b1;
    end
  end

  assign irq_o       = |(isr_q & ier_q);
  assign fault_clr_o = wr_en && (apb_i.paddr == `PWM_FAULT_OFS) && apb_i.pwdata[1];

  // Read mux, zero for unmapped
  always_comb begin
    prdata_o = '0;
    if (apb_i.psel && !apb_i.pwrite) begin
      case (apb_i.paddr)
        `PWM_GCR_OFS:    prdata_o[1:0] = {glb_q.out_en, glb_q.en};
        `PWM_PERIOD_OFS: prdata_o[`PWM_CNT_W-1:0] = glb_q.period;
        `PWM_PSC_OFS:    prdata_o[`PWM_CNT_W-1:0] = glb_q.psc;
        `PWM_CNT_OFS:    prdata_o[`PWM_CNT_W-1:0] = cnt_i;  // Live count
        `PWM_DT_OFS:     prdata_o = {glb_q.dt_fall, glb_q.dt_rise};
        `PWM_FAULT_OFS: begin
          prdata_o[3:0]              = {fault_q.auto_clr, fault_q.pol, fault_flag_i, fault_lvl_i};
          prdata_o[`PWM_FILT_W+7:8] = fault_q.filt;
        end
        `PWM_IER_OFS:    prdata_o[1:0] = ier_q;
        `PWM_ISR_OFS:    prdata_o[1:0] = isr_q;
        default: begin
          if (ch_hit && ch_reg == `PWM_CCR_OFS) begin
            prdata_o[4:0] = {ch_q[ch_idx].fault_en, ch_q[ch_idx].dt_en,
                             ch_q[ch_idx].comp_en, ch_q[ch_idx].pol, ch_q[ch_idx].en};
          end else if (ch_hit && ch_reg == `PWM_DUTY_OFS) begin
            prdata_o[`PWM_CNT_W-1:0] = ch_q[ch_idx].duty;
          end
        end
      endcase
    end
  end

  assign glb_cfg_o   = glb_q;
  assign fault_cfg_o = fault_q;
  assign ch_cfg_o    = ch_q;

  // Setup phase is always followed by its access phase
  a_apb_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (apb_i.psel && !apb_i.penable) |=> (apb_i.psel && apb_i.penable));

endmodule

`default_nettype wire

/* hdl/pwm_timebase.sv */
/*
  PWM time base
  Prescaler tick and edge-aligned period counter with wrap pulse
*/
`timescale 1ns/1ps
`default_nettype none

module pwm_timebase (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  pwm_pkg::pwm_glb_cfg_t cfg_i,
  output pwm_pkg::pwm_cnt_t     cnt_o,
  output logic                  tick_o,
  output logic                  wrap_o
);
  import pwm_pkg::*;

  pwm_psc_t psc_cnt_q;
  pwm_cnt_t cnt_q;
  pwm_cnt_t last_cnt;
  logic     at_last;

  // ====================
  // Prescaler
  // ====================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      psc_cnt_q <= '0;
    end else if (!cfg_i.en || tick_o) begin
      psc_cnt_q <= '0;  // Held while disabled
    end else begin
      psc_cnt_q <= psc_cnt_q + 1'b1;
    end
  end

  assign tick_o = cfg_i.en && (psc_cnt_q >= cfg_i.psc);  // Every PSC+1 clocks

  // ====================
  // Period counter
  // ====================
  assign last_cnt = cfg_i.period - 1'b1;
  assign at_last  = (cnt_q >= last_cnt);  // Also catches a shrunk period

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (!cfg_i.en) begin
      cnt_q <= '0;
    end else if (tick_o) begin
      cnt_q <= at_last ? '0 : cnt_q + 1'b1;
    end
  end

  assign cnt_o  = cnt_q;
  assign wrap_o = tick_o && at_last;  // One clock per period

  // Running counter moves only on a tick
  a_cnt_on_tick: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cfg_i.en && !tick_o) |=> $stable(cnt_o));

endmodule

`default_nettype wire

/* hdl/pwm_fault.sv */
/*
  Fault input conditioning
  Polarity, debounce filter, sticky flag with auto-clear and W1C
*/
`timescale 1ns/1ps
`default_nettype none

module pwm_fault (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    fault_i,
  input  pwm_pkg::pwm_fault_cfg_t cfg_i,
  input  logic                    clr_i,
  output logic                    lvl_o,
  output logic                    flag_o
);
  import pwm_pkg::*;

  logic      fault_act;  // Polarity corrected input
  logic      lvl_q;
  logic      flag_q;
  pwm_filt_t filt_cnt_q;

  assign fault_act = fault_i ^ cfg_i.pol;  // Pol set means active low

  // ====================
  // Debounce
  // ====================
  // Level follows input after FILT+1 differing clocks in a row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lvl_q      <= 1'b0;
      filt_cnt_q <= '0;
    end else if (fault_act == lvl_q) begin
      filt_cnt_q <= '0;  // Glitch ends, restart
    end else if (filt_cnt_q >= cfg_i.filt) begin
      lvl_q      <= fault_act;
      filt_cnt_q <= '0;
    end else begin
      filt_cnt_q <= filt_cnt_q + 1'b1;
    end
  end

  // Sticky flag, active level has priority over any clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      flag_q <= 1'b0;
    end else if (lvl_q) begin
      flag_q <= 1'b1;
    end else if (clr_i || cfg_i.auto_clr) begin
      flag_q <= 1'b0;
    end
  end

  assign lvl_o  = lvl_q;
  assign flag_o = flag_q;

endmodule

`default_nettype wire

/* hdl/pwm_channel.sv */
/*
  One PWM channel
  Duty compare, polarity, dead-time sequencer, output gating
*/
`timescale 1ns/1ps
`default_nettype none

module pwm_channel (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  pwm_pkg::pwm_glb_cfg_t glb_i,
  input  pwm_pkg::pwm_ch_cfg_t  cfg_i,
  input  pwm_pkg::pwm_cnt_t     cnt_i,
  input  logic                  tick_i,
  input  logic                  fault_i,  // Sticky fault flag
  output logic                  pwm_o,
  output logic                  pwm_n_o
);
  import pwm_pkg::*;

  pwm_dt_state_e state_q;
  pwm_cnt_t      dt_cnt_q;  // Ticks spent in dead state
  logic          pol_sig;
  logic          pwm_sel;
  logic          pwm_n_sel;
  logic          gate;

  // Edge aligned compare then polarity
  assign pol_sig = (cfg_i.en && (cnt_i < cfg_i.duty)) ^ cfg_i.pol;

  // ====================
  // Dead-time FSM
  // ====================
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= OFF;
      dt_cnt_q <= '0;
    end else if (!cfg_i.dt_en) begin
      state_q  <= pol_sig ? ON : OFF;  // Track while bypassed
      dt_cnt_q <= '0;
    end else begin
      unique case (state_q)
        OFF: begin
          if (pol_sig) begin
            state_q  <= DT_RISE;
            dt_cnt_q <= '0;
          end
        end
        DT_RISE: begin
          if (!pol_sig) begin
            state_q <= OFF;  // Pulse shorter than dead-time
          end else if (tick_i) begin
            if (dt_cnt_q >= glb_i.dt_rise) state_q <= ON;  // DT_RISE+1 ticks
            else dt_cnt_q <= dt_cnt_q + 1'b1;
          end
        end
        ON: begin
          if (!pol_sig) begin
            state_q  <= DT_FALL;
            dt_cnt_q <= '0;
          end
        end
        DT_FALL: begin
          if (pol_sig) begin
            state_q <= ON;
          end else if (tick_i) begin
            if (dt_cnt_q >= glb_i.dt_fall) state_q <= OFF;
            else dt_cnt_q <= dt_cnt_q + 1'b1;
          end
        end
        default: state_q <= OFF;
      endcase
    end
  end

  // Both low in dead states, decoded from the state flops
  assign pwm_sel   = cfg_i.dt_en ? (state_q == ON)  : pol_sig;
  assign pwm_n_sel = cfg_i.dt_en ? (state_q == OFF) : !pol_sig;

  // Output gating
  assign gate    = glb_i.en && glb_i.out_en && !(cfg_i.fault_en && fault_i);
  assign pwm_o   = gate && pwm_sel;
  assign pwm_n_o = gate && cfg_i.comp_en && pwm_n_sel;

  // A dead state separates the two outputs in both directions
  a_dead_before_on: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cfg_i.dt_en && pwm_n_o) |=> (!cfg_i.dt_en || !pwm_o));

  a_dead_before_off: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (cfg_i.dt_en && pwm_o) |=> (!cfg_i.dt_en || !pwm_n_o));

endmodule

`default_nettype wire

/* hdl/pwm_top.sv */
/*
  PWM controller top level
  Register file, time base, fault unit, channel array
*/
`timescale 1ns/1ps
`default_nettype none
`include "pwm_params.svh"

module pwm_top (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  pwm_pkg::pwm_apb_req_t  apb_i,
  output pwm_pkg::pwm_data_t     prdata_o,
  input  logic                   fault_i,
  output logic [`PWM_NUM_CH-1:0] pwm_o,
  output logic [`PWM_NUM_CH-1:0] pwm_n_o,
  output logic                   irq_o
);
  import pwm_pkg::*;

  pwm_glb_cfg_t   glb_cfg;
  pwm_fault_cfg_t fault_cfg;
  pwm_ch_cfg_t    ch_cfg [`PWM_NUM_CH];
  pwm_cnt_t       cnt;
  logic           tick, wrap;
  logic           fault_lvl, fault_flag, fault_clr;

  // ====================
  // Control path
  // ====================
  pwm_regs u_regs (
    .clk_i, .rst_ni, .apb_i, .prdata_o,
    .cnt_i(cnt), .wrap_i(wrap),
    .fault_lvl_i(fault_lvl), .fault_flag_i(fault_flag), .fault_clr_o(fault_clr),
    .glb_cfg_o(glb_cfg), .fault_cfg_o(fault_cfg), .ch_cfg_o(ch_cfg),
    .irq_o
  );

  pwm_timebase u_timebase (
    .clk_i, .rst_ni, .cfg_i(glb_cfg), .cnt_o(cnt), .tick_o(tick), .wrap_o(wrap)
  );

  pwm_fault u_fault (
    .clk_i, .rst_ni, .fault_i, .cfg_i(fault_cfg), .clr_i(fault_clr),
    .lvl_o(fault_lvl), .flag_o(fault_flag)
  );

  // One channel per output pair
  for (genvar i = 0; i < `PWM_NUM_CH; i++) begin : gen_ch
    pwm_channel u_ch (
      .clk_i, .rst_ni, .glb_i(glb_cfg), .cfg_i(ch_cfg[i]),
      .cnt_i(cnt), .tick_i(tick), .fault_i(fault_flag),
      .pwm_o(pwm_o[i]), .pwm_n_o(pwm_n_o[i])
    );
  end

endmodule

`default_nettype wire

/* tb/pwm_tb.sv */
/*
  Testbench of the PWM controller
  APB driver tasks, reference high count, window comparator, directed tests
*/
`timescale 1ns/1ps
`default_nettype none
`include "pwm_params.svh"

module pwm_tb;
  import pwm_pkg::*;

  localparam int NUM_CH  = `PWM_NUM_CH;
  localparam int FILT    = 3;     // Fault debounce length used in tests
  localparam int TIMEOUT = 1000;  // Clocks per window wait

  logic              clk_i;
  logic              rst_ni;
  pwm_apb_req_t      apb;
  pwm_data_t         prdata;
  logic              fault_i;
  logic [NUM_CH-1:0] pwm_o;
  logic [NUM_CH-1:0] pwm_n_o;
  logic              irq_o;

  // Shadow of programmed config, feeds the reference
  int                duty_q [NUM_CH];
  logic [NUM_CH-1:0] pol_q;
  logic [NUM_CH-1:0] comp_q;
  int                psc_v;
  int                period_v;
  integer            seed;
  logic              meas_en = 1'b0;  // Comparator running
  logic              dt_mode = 1'b0;  // Dead-time bounds instead of exact counts
  int                win_done = 0;
  int                clk_cnt = 0;
  int                hi_cnt [NUM_CH];
  int                hi_n_cnt [NUM_CH];

  pwm_top dut (
    .clk_i, .rst_ni, .apb_i(apb), .prdata_o(prdata), .fault_i,
    .pwm_o, .pwm_n_o, .irq_o
  );

  always #5 clk_i = ~clk_i;  // 10 ns period

  // ====================
  // Checking
  // ====================
  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "Simulation stopped at first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
      stop_on_error();
    end
  endtask

  // High clocks of one channel over (PSC+1)*PERIOD clocks
  function automatic int expected_high_count(input int duty, input int psc,
                                             input int period, input logic pol);
    int win;
    int hi;
    win = (psc + 1) * period;
    hi  = ((duty < period) ? duty : period) * (psc + 1);  // Duty saturates at period
    return pol ? win - hi : hi;
  endfunction

  // Window comparator, samples outputs mid-cycle
  always @(negedge clk_i) begin : compare
    int win;
    int exp_hi;
    win = (psc_v + 1) * period_v;
    if (!meas_en) begin
      clk_cnt = 0;
      for (int i = 0; i < NUM_CH; i++) begin
        hi_cnt[i]   = 0;
        hi_n_cnt[i] = 0;
      end
    end else begin
      for (int i = 0; i < NUM_CH; i++) begin
        hi_cnt[i]   = hi_cnt[i] + pwm_o[i];
        hi_n_cnt[i] = hi_n_cnt[i] + pwm_n_o[i];
        if (dt_mode) check_val($sformatf("pwm_o[%0d] & pwm_n_o[%0d]", i, i),
                               pwm_o[i] & pwm_n_o[i], 0);
        else if (comp_q[i]) check_val($sformatf("pwm_n_o[%0d]", i), pwm_n_o[i], !pwm_o[i]);
      end
      clk_cnt++;
      if (clk_cnt == win) begin  // Window complete
        for (int i = 0; i < NUM_CH; i++) begin
          exp_hi = expected_high_count(duty_q[i], psc_v, period_v, pol_q[i]);
          if (dt_mode) begin
            check_val($sformatf("pwm_o[%0d] count below %0d", i, exp_hi),
                      hi_cnt[i] < exp_hi, 1);
            check_val($sformatf("pwm_n_o[%0d] count below %0d", i, win - exp_hi),
                      hi_n_cnt[i] < win - exp_hi, 1);
          end else begin
            check_val($sformatf("pwm_o[%0d] high count", i), hi_cnt[i], exp_hi);
            check_val($sformatf("pwm_n_o[%0d] high count", i), hi_n_cnt[i],
                      comp_q[i] ? win - exp_hi : 0);
          end
          hi_cnt[i]   = 0;
          hi_n_cnt[i] = 0;
        end
        clk_cnt = 0;
        win_done++;
      end
    end
  end

  // ====================
  // APB driver
  // ====================
  task automatic apb_write(input pwm_addr_t addr, input pwm_data_t data);
    @(negedge clk_i);
    apb.psel    = 1'b1;  // Setup phase
    apb.penable = 1'b0;
    apb.pwrite  = 1'b1;
    apb.paddr   = addr;
    apb.pwdata  = data;
    @(negedge clk_i);
    apb.penable = 1'b1;  // Access, write lands at next rising edge
    @(negedge clk_i);
    apb = '0;
  endtask

  task automatic apb_read(input pwm_addr_t addr, output pwm_data_t data);
    @(negedge clk_i);
    apb.psel    = 1'b1;
    apb.penable = 1'b0;
    apb.pwrite  = 1'b0;
    apb.paddr   = addr;
    @(negedge clk_i);
    apb.penable = 1'b1;
    @(negedge clk_i);
    data = prdata;  // Combinational read data, taken before release
    apb  = '0;
  endtask

  task automatic check_read(input pwm_addr_t addr, input pwm_data_t exp, input string name);
    pwm_data_t data;
    apb_read(addr, data);
    check_val(name, data, exp);
  endtask

  function automatic pwm_addr_t ch_addr(input int ch, input pwm_addr_t ofs);
    return pwm_addr_t'(`PWM_CH_BASE + ch * `PWM_CH_STRIDE + ofs);
  endfunction

  // DUTY then CCR for every channel from the shadow
  task automatic program_channels(input logic dt, input logic [NUM_CH-1:0] fault_mask);
    for (int i = 0; i < NUM_CH; i++) begin
      apb_write(ch_addr(i, `PWM_DUTY_OFS), duty_q[i]);
      apb_write(ch_addr(i, `PWM_CCR_OFS), {27'b0, fault_mask[i], dt, comp_q[i], pol_q[i], 1'b1});
    end
  endtask

  // ====================
  // Waits
  // ====================
  task automatic idle_clocks(input int n);
    repeat (n) @(negedge clk_i);
  endtask

  task automatic measure_windows(input int n, input logic dt);
    int start;
    dt_mode = dt;
    @(posedge clk_i);
    meas_en = 1'b1;
    start   = win_done;
    for (int t = 0; t < TIMEOUT; t++) begin
      @(posedge clk_i);
      if (win_done >= start + n) break;
    end
    meas_en = 1'b0;
    if (win_done < start + n) begin
      $display("Timeout: comparator did not finish %0d windows", n);
      stop_on_error();
    end
  endtask

  task automatic wait_irq(input int limit);
    for (int t = 0; t < limit; t++) begin
      @(negedge clk_i);
      if (irq_o) break;
    end
    if (!irq_o) begin
      $display("Timeout: irq_o did not rise within %0d clocks", limit);
      stop_on_error();
    end
  endtask

  task automatic wait_fault_idle();
    pwm_data_t data;
    data = '1;
    for (int t = 0; t < 50 && data[0]; t++) begin
      apb_read(`PWM_FAULT_OFS, data);  // Poll filtered level
    end
    if (data[0]) begin
      $display("Timeout: filtered fault level stayed high after input release");
      stop_on_error();
    end
  endtask

  // ====================
  // Test sequence
  // ====================
  initial begin
    clk_i   = 1'b0;
    rst_ni  = 1'b0;
    apb     = '0;
    fault_i = 1'b0;
    seed    = 3;
    psc_v   = 2;
    period_v = 20;
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("pwm_o after reset", pwm_o, 0);
    check_val("pwm_n_o after reset", pwm_n_o, 0);
    check_val("irq_o after reset", irq_o, 0);

    // Register read-back, masked fields
    check_read(`PWM_PERIOD_OFS, 32'h0000_FFFF, "PERIOD reset value");
    check_read(`PWM_GCR_OFS, 32'h0, "GCR reset value");
    apb_write(`PWM_PERIOD_OFS, 32'hFFFF_0014);
    check_read(`PWM_PERIOD_OFS, 32'h0000_0014, "PERIOD");
    apb_write(`PWM_PSC_OFS, 32'hABCD_0002);
    check_read(`PWM_PSC_OFS, 32'h0000_0002, "PSC");
    apb_write(`PWM_DT_OFS, 32'h0005_0007);
    check_read(`PWM_DT_OFS, 32'h0005_0007, "DT");
    apb_write(`PWM_FAULT_OFS, 32'hFFFF_AB08);  // Auto-clear, filter 0xAB
    check_read(`PWM_FAULT_OFS, 32'h0000_AB08, "FAULT");
    apb_write(`PWM_IER_OFS, 32'hFFFF_FFFC);
    check_read(`PWM_IER_OFS, 32'h0, "IER");
    apb_write(ch_addr(2, `PWM_CCR_OFS), 32'hFFFF_FFE6);
    check_read(ch_addr(2, `PWM_CCR_OFS), 32'h0000_0006, "CCR2");
    apb_write(ch_addr(1, `PWM_DUTY_OFS), 32'h1234_5678);
    check_read(ch_addr(1, `PWM_DUTY_OFS), 32'h0000_5678, "DUTY1");
    check_read(8'h20, 32'h0, "unmapped 0x20");
    check_read(8'h48, 32'h0, "unmapped 0x48");
    check_read(8'h80, 32'h0, "unmapped 0x80");

    // Duty and polarity, random duties
    apb_write(`PWM_FAULT_OFS, FILT << 8);  // No auto-clear
    for (int i = 0; i < NUM_CH; i++) begin
      duty_q[i] = $unsigned($random(seed)) % period_v;
      pol_q[i]  = 1'(i % 2);
      comp_q[i] = (i >= 2);
    end
    program_channels(1'b0, '0);
    apb_write(`PWM_GCR_OFS, 32'h3);
    idle_clocks(60);
    measure_windows(2, 1'b0);

    // Dead-time, rise and fall of 2 ticks
    apb_write(`PWM_DT_OFS, 32'h0002_0002);
    duty_q = '{6, 10, 14, 8};
    pol_q  = '0;
    comp_q = '1;
    program_channels(1'b1, '0);
    idle_clocks(120);
    measure_windows(2, 1'b1);

    // Fault shutdown on channels 0 and 1
    duty_q = '{10, 10, 10, 10};
    comp_q = '0;
    program_channels(1'b0, 4'b0011);
    idle_clocks(60);
    measure_windows(1, 1'b0);
    @(negedge clk_i);
    fault_i = 1'b1;
    idle_clocks(FILT + 3);
    check_val("pwm_o[1:0] under fault", pwm_o[1:0], 0);
    duty_q[0] = 0;  // Shut channels read as zero duty
    duty_q[1] = 0;
    measure_windows(2, 1'b0);
    check_read(`PWM_FAULT_OFS, (FILT << 8) | 32'h3, "FAULT under fault");
    @(negedge clk_i);
    fault_i = 1'b0;
    wait_fault_idle();
    check_read(`PWM_FAULT_OFS, (FILT << 8) | 32'h2, "FAULT flag held");
    apb_write(`PWM_FAULT_OFS, (FILT << 8) | 32'h2);  // W1C flag
    check_read(`PWM_FAULT_OFS, FILT << 8, "FAULT after clear");
    duty_q[0] = 10;
    duty_q[1] = 10;
    measure_windows(2, 1'b0);

    // Interrupts
    apb_write(`PWM_GCR_OFS, 32'h0);
    apb_write(`PWM_ISR_OFS, 32'h3);
    apb_write(`PWM_IER_OFS, 32'h1);
    check_val("irq_o with ISR clear", irq_o, 0);
    apb_write(`PWM_GCR_OFS, 32'h3);
    wait_irq((psc_v + 1) * period_v + 5);
    apb_write(`PWM_ISR_OFS, 32'h1);
    check_val("irq_o after wrap clear", irq_o, 0);
    wait_irq((psc_v + 1) * period_v + 5);
    apb_write(`PWM_IER_OFS, 32'h2);
    apb_write(`PWM_ISR_OFS, 32'h3);
    check_val("irq_o with fault idle", irq_o, 0);
    @(negedge clk_i);
    fault_i = 1'b1;
    wait_irq(FILT + 10);
    @(negedge clk_i);
    fault_i = 1'b0;
    wait_fault_idle();
    apb_write(`PWM_FAULT_OFS, (FILT << 8) | 32'h2);
    apb_write(`PWM_ISR_OFS, 32'h3);
    check_val("irq_o after fault clear", irq_o, 0);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+hdl
hdl/pwm_pkg.sv
hdl/pwm_regs.sv
hdl/pwm_timebase.sv
hdl/pwm_fault.sv
hdl/pwm_channel.sv
hdl/pwm_top.sv
tb/pwm_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the PWM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f build.f --top-module pwm_tb -o pwm_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/pwm_sim
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit "$status"
fi
exit 0
